//--- Makefile
BUILD := obj_dir

.PHONY: compile run clean

compile:
	verilator --binary --timing --top-module pat_tb -f build.f -Mdir $(BUILD) -o pat_tb

run: compile
	$(BUILD)/pat_tb | awk '{ print } /^=== PASS ===$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(BUILD)

//--- build.f
+incdir+verification
hdl/pat_pkg.sv
hdl/pat_regfile.sv
hdl/pat_decode.sv
hdl/pat_execute.sv
hdl/pat_result.sv
hdl/pat_core.sv
verification/tb_clock.sv
verification/pat_tb.sv

//--- hdl/pat_core.sv
`timescale 1ns/100ps

module pat_core (
	input logic clk,
	input logic reset,
	input logic i_instr_valid,
	input pat_pkg::instr_t i_instr,
	input pat_pkg::data_t i_in_data [pat_pkg::N_IN_PORTS],
	input logic i_out_ready,
	output logic o_instr_ready,
	output logic o_out_valid,
	output pat_pkg::data_t o_out_data
);
	import pat_pkg::*;

	logic [REG_ADR_W-1:0] rd_adr_a, rd_adr_b;
	data_t rd_data_a, rd_data_b;
	logic dec_valid, exe_ready;
	dec_t dec;
	logic exe_valid, res_accept;
	res_t res;
	logic [REG_ADR_W-1:0] pend_rn;
	commit_e pend_kind;
	logic wr_en;
	logic [REG_ADR_W-1:0] wr_adr;
	data_t wr_data;

	pat_decode u_decode (
		.clk(clk), .reset(reset),
		.i_instr_valid(i_instr_valid), .i_instr(i_instr), .i_in_data(i_in_data),
		.i_rd_data_a(rd_data_a), .i_rd_data_b(rd_data_b),
		.i_exe_ready(exe_ready), .i_exe_pend_rn(pend_rn), .i_exe_pend_kind(pend_kind),
		.o_instr_ready(o_instr_ready), .o_rd_adr_a(rd_adr_a), .o_rd_adr_b(rd_adr_b),
		.o_dec_valid(dec_valid), .o_dec(dec)
	);

	pat_execute u_execute (
		.clk(clk), .reset(reset),
		.i_dec_valid(dec_valid), .i_dec(dec), .i_res_accept(res_accept),
		.o_exe_ready(exe_ready), .o_exe_valid(exe_valid), .o_res(res),
		.o_pend_rn(pend_rn), .o_pend_kind(pend_kind)
	);

	pat_result u_result (
		.clk(clk), .reset(reset),
		.i_exe_valid(exe_valid), .i_res(res), .i_out_ready(i_out_ready),
		.o_res_accept(res_accept), .o_wr_en(wr_en), .o_wr_adr(wr_adr),
		.o_wr_data(wr_data), .o_out_valid(o_out_valid), .o_out_data(o_out_data)
	);

	pat_regfile u_regfile (
		.clk(clk), .reset(reset),
		.i_rd_adr_a(rd_adr_a), .i_rd_adr_b(rd_adr_b),
		.i_wr_en(wr_en), .i_wr_adr(wr_adr), .i_wr_data(wr_data),
		.o_rd_data_a(rd_data_a), .o_rd_data_b(rd_data_b)
	);

endmodule

//--- hdl/pat_decode.sv
`timescale 1ns/100ps

module pat_decode (
	input logic clk,
	input logic reset,
	input logic i_instr_valid,
	input pat_pkg::instr_t i_instr,
	input pat_pkg::data_t i_in_data [pat_pkg::N_IN_PORTS],
	input pat_pkg::data_t i_rd_data_a,
	input pat_pkg::data_t i_rd_data_b,
	input logic i_exe_ready,
	input logic [pat_pkg::REG_ADR_W-1:0] i_exe_pend_rn,
	input pat_pkg::commit_e i_exe_pend_kind,
	output logic o_instr_ready,
	output logic [pat_pkg::REG_ADR_W-1:0] o_rd_adr_a,
	output logic [pat_pkg::REG_ADR_W-1:0] o_rd_adr_b,
	output logic o_dec_valid,
	output pat_pkg::dec_t o_dec
);
	import pat_pkg::*;

	logic [3:0] op_i3, op_i0;
	logic [2:0] imm3;
	logic is_i8, is_i3;
	alu_op_e alu_op;
	commit_e kind;
	logic uses_a, uses_b;
	logic dec_hit, exe_hit, hazard;
	data_t in_sel, opnd_b;

	assign op_i3 = i_instr.imm8[7:4];
	assign op_i0 = i_instr.imm8[3:0];
	assign imm3 = i_instr.imm8[2:0];

	// class from the two prefixes, i0 is what remains
	assign is_i8 = (i_instr.opcode_i8 != I8_PREFIX_I3);
	assign is_i3 = !is_i8 && (op_i3 != I3_PREFIX_I0);

	// ========================================
	// opcode mapping
	// ========================================
	always_comb
	begin
		alu_op = ALU_OR;
		kind = COMMIT_REG;
		if (is_i8)
		begin
			case (i_instr.opcode_i8)
				I8_ORI, I8_ORR: alu_op = ALU_OR;
				I8_ANDI, I8_ANDR: alu_op = ALU_AND;
				I8_ADDI, I8_ADDR: alu_op = ALU_ADD;
				I8_SUBI, I8_SUBR: alu_op = ALU_SUB;
				I8_LDI: alu_op = ALU_PASS_B;
				default: kind = COMMIT_NONE; // dropped ops act as nop
			endcase
		end
		else if (is_i3)
		begin
			case (op_i3)
				I3_SHLZI, I3_SHLZR: alu_op = ALU_SHLZ;
				I3_SHLOI, I3_SHLOR: alu_op = ALU_SHLO;
				I3_SHRZI, I3_SHRZR: alu_op = ALU_SHRZ;
				I3_SHROI, I3_SHROR: alu_op = ALU_SHRO;
				I3_IN: alu_op = ALU_PASS_B;
				I3_OUT: kind = COMMIT_OUT;
				default: kind = COMMIT_NONE;
			endcase
		end
		else
		begin
			case (op_i0)
				I0_NOT: alu_op = ALU_NOT;
				I0_TEST: kind = COMMIT_FLAGS;
				default: kind = COMMIT_NONE; // includes nop
			endcase
		end
	end

	// register forms have an odd opcode, i3 only below IN
	assign uses_b = (kind == COMMIT_REG) &&
		(is_i8 ? i_instr.opcode_i8[0] : (is_i3 && !op_i3[3] && op_i3[0]));
	assign uses_a = (kind != COMMIT_NONE) && (alu_op != ALU_PASS_B);

	// one-hot port select
	always_comb
	begin
		case (imm3)
			3'b010: in_sel = i_in_data[1];
			3'b100: in_sel = i_in_data[2];
			default: in_sel = i_in_data[0];
		endcase
	end

	always_comb
	begin
		if (is_i3 && op_i3 == I3_IN)
			opnd_b = in_sel;
		else if (uses_b)
			opnd_b = i_rd_data_b;
		else if (is_i8)
			opnd_b = i_instr.imm8;
		else
			opnd_b = {5'b0, imm3};
	end

	assign o_rd_adr_a = i_instr.rn;
	assign o_rd_adr_b = imm3;

	// ========================================
	// hazards and handshake
	// ========================================
	assign dec_hit = o_dec_valid && (o_dec.kind == COMMIT_REG);
	assign exe_hit = (i_exe_pend_kind == COMMIT_REG);
	assign hazard = (uses_a && ((dec_hit && o_dec.rn == i_instr.rn) ||
		(exe_hit && i_exe_pend_rn == i_instr.rn))) ||
		(uses_b && ((dec_hit && o_dec.rn == imm3) || (exe_hit && i_exe_pend_rn == imm3)));

	assign o_instr_ready = (!o_dec_valid || i_exe_ready) && !hazard;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			o_dec_valid <= 1'b0;
		else if (i_instr_valid && o_instr_ready)
			o_dec_valid <= 1'b1;
		else if (i_exe_ready)
			o_dec_valid <= 1'b0; // moved on to execute
	end

	always_ff @(posedge clk)
	begin
		if (i_instr_valid && o_instr_ready)
		begin
			o_dec.alu_op <= alu_op;
			o_dec.a <= (alu_op == ALU_PASS_B) ? '0 : i_rd_data_a; // ldi ors into zero
			o_dec.b <= opnd_b;
			o_dec.rn <= i_instr.rn;
			o_dec.cond <= i_instr.cond;
			o_dec.kind <= kind;
		end
	end

endmodule

//--- hdl/pat_execute.sv
`timescale 1ns/100ps

module pat_execute (
	input logic clk,
	input logic reset,
	input logic i_dec_valid,
	input pat_pkg::dec_t i_dec,
	input logic i_res_accept,
	output logic o_exe_ready,
	output logic o_exe_valid,
	output pat_pkg::res_t o_res,
	output logic [pat_pkg::REG_ADR_W-1:0] o_pend_rn,
	output pat_pkg::commit_e o_pend_kind
);
	import pat_pkg::*;

	logic [2:0] sh_amt;
	data_t alu_y;
	data_t y_next;

	// shifts move by 1 to 4 places
	assign sh_amt = {1'b0, i_dec.b[1:0]} + 3'd1;

	// ========================================
	// alu
	// ========================================
	always_comb
	begin
		case (i_dec.alu_op)
			ALU_OR: alu_y = i_dec.a | i_dec.b;
			ALU_AND: alu_y = i_dec.a & i_dec.b;
			ALU_ADD: alu_y = i_dec.a + i_dec.b; // wraps at 8 bits
			ALU_SUB: alu_y = i_dec.a - i_dec.b;
			ALU_NOT: alu_y = ~i_dec.a;
			ALU_PASS_B: alu_y = i_dec.b;
			ALU_SHLZ: alu_y = i_dec.a << sh_amt;
			ALU_SHLO: alu_y = ~((~i_dec.a) << sh_amt); // ones shifted in at bit 0
			ALU_SHRZ: alu_y = i_dec.a >> sh_amt;
			ALU_SHRO: alu_y = ~((~i_dec.a) >> sh_amt);
			default: alu_y = i_dec.a;
		endcase
	end

	// out and test carry operand a straight through
	assign y_next = (i_dec.kind == COMMIT_OUT || i_dec.kind == COMMIT_FLAGS) ?
		i_dec.a : alu_y;

	// ========================================
	// execute register
	// ========================================
	assign o_exe_ready = !o_exe_valid || i_res_accept;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			o_exe_valid <= 1'b0;
		else if (o_exe_ready)
			o_exe_valid <= i_dec_valid;
	end

	always_ff @(posedge clk)
	begin
		if (i_dec_valid && o_exe_ready)
		begin
			o_res.y <= y_next;
			o_res.rn <= i_dec.rn;
			o_res.cond <= i_dec.cond;
			o_res.kind <= i_dec.kind;
		end
	end

	// pending write seen by decode
	assign o_pend_rn = o_res.rn;
	assign o_pend_kind = o_exe_valid ? o_res.kind : COMMIT_NONE;

endmodule

//--- hdl/pat_pkg.sv
package pat_pkg;

	// ========================================
	// widths
	// ========================================
	localparam int DATA_W = 8;
	localparam int REG_ADR_W = 3;
	localparam int N_IN_PORTS = 3;

	typedef logic [DATA_W-1:0] data_t;

	// ========================================
	// opcode spaces
	// ========================================
	typedef enum logic [3:0] {
		I8_ORI = 4'h0,
		I8_ORR = 4'h1,
		I8_ANDI = 4'h2,
		I8_ANDR = 4'h3,
		I8_ADDI = 4'h4,
		I8_ADDR = 4'h5,
		I8_SUBI = 4'h6,
		I8_SUBR = 4'h7,
		I8_LDI = 4'h8,
		I8_PREFIX_I3 = 4'hF // escape into i3 space
	} opcode_i8_e;

	typedef enum logic [3:0] {
		I3_SHLZI = 4'h0,
		I3_SHLZR = 4'h1,
		I3_SHLOI = 4'h2,
		I3_SHLOR = 4'h3,
		I3_SHRZI = 4'h4,
		I3_SHRZR = 4'h5,
		I3_SHROI = 4'h6,
		I3_SHROR = 4'h7,
		I3_IN = 4'h8,
		I3_OUT = 4'hB,
		I3_PREFIX_I0 = 4'hF // escape into i0 space
	} opcode_i3_e;

	typedef enum logic [3:0] {
		I0_NOT = 4'h0,
		I0_TEST = 4'h2,
		I0_NOP = 4'h5
	} opcode_i0_e;

	typedef enum logic [1:0] {
		COND_Z = 2'd0,
		COND_NZ = 2'd1,
		COND_N = 2'd2,
		COND_AL = 2'd3
	} cond_e;

	typedef enum logic [3:0] {
		ALU_OR, ALU_AND, ALU_ADD, ALU_SUB, ALU_NOT, ALU_PASS_B,
		ALU_SHLZ, ALU_SHLO, ALU_SHRZ, ALU_SHRO
	} alu_op_e;

	// what a result does when it commits
	typedef enum logic [1:0] {
		COMMIT_NONE, COMMIT_REG, COMMIT_OUT, COMMIT_FLAGS
	} commit_e;

	// 23-bit instruction word
	typedef struct packed {
		logic [REG_ADR_W-1:0] rn;    // 22..20
		logic [4:0] rsvd_fieldp;     // 19..15, ignored
		cond_e cond;                 // 14..13
		logic rsvd_field_op;         // 12, ignored
		logic [3:0] opcode_i8;       // 11..8
		logic [7:0] imm8;            // i3 opcode in 7..4, i0 opcode in 3..0
	} instr_t;

	// decode -> execute
	typedef struct packed {
		alu_op_e alu_op;
		data_t a;
		data_t b;
		logic [REG_ADR_W-1:0] rn;
		cond_e cond;
		commit_e kind;
	} dec_t;

	// execute -> result
	typedef struct packed {
		data_t y;
		logic [REG_ADR_W-1:0] rn;
		cond_e cond;
		commit_e kind;
	} res_t;

endpackage

//--- hdl/pat_regfile.sv
`timescale 1ns/100ps

module pat_regfile (
	input logic clk,
	input logic reset,
	input logic [pat_pkg::REG_ADR_W-1:0] i_rd_adr_a,
	input logic [pat_pkg::REG_ADR_W-1:0] i_rd_adr_b,
	input logic i_wr_en,
	input logic [pat_pkg::REG_ADR_W-1:0] i_wr_adr,
	input pat_pkg::data_t i_wr_data,
	output pat_pkg::data_t o_rd_data_a,
	output pat_pkg::data_t o_rd_data_b
);
	import pat_pkg::*;

	data_t regs [2**REG_ADR_W];

	// combinational reads return the stored value, no bypass
	assign o_rd_data_a = regs[i_rd_adr_a];
	assign o_rd_data_b = regs[i_rd_adr_b];

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < 2**REG_ADR_W; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (i_wr_en)
		begin
			regs[i_wr_adr] <= i_wr_data;
		end
	end

endmodule

//--- hdl/pat_result.sv
`timescale 1ns/100ps

module pat_result (
	input logic clk,
	input logic reset,
	input logic i_exe_valid,
	input pat_pkg::res_t i_res,
	input logic i_out_ready,
	output logic o_res_accept,
	output logic o_wr_en,
	output logic [pat_pkg::REG_ADR_W-1:0] o_wr_adr,
	output pat_pkg::data_t o_wr_data,
	output logic o_out_valid,
	output pat_pkg::data_t o_out_data
);
	import pat_pkg::*;

	logic flag_z, flag_n;
	logic cond_pass;
	logic commit;

	// ========================================
	// condition check
	// ========================================
	always_comb
	begin
		case (i_res.cond)
			COND_Z: cond_pass = flag_z;
			COND_NZ: cond_pass = !flag_z;
			COND_N: cond_pass = flag_n;
			default: cond_pass = 1'b1;
		endcase
	end

	// a passing out waits while the port still holds data
	assign o_res_accept = !(i_exe_valid && i_res.kind == COMMIT_OUT && cond_pass &&
		o_out_valid && !i_out_ready);

	// skipped items still leave, they just do nothing
	assign commit = i_exe_valid && o_res_accept && cond_pass;

	assign o_wr_en = commit && (i_res.kind == COMMIT_REG);
	assign o_wr_adr = i_res.rn;
	assign o_wr_data = i_res.y;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			flag_z <= 1'b1;
			flag_n <= 1'b0;
		end
		else if (commit && i_res.kind == COMMIT_FLAGS)
		begin
			flag_z <= (i_res.y == '0);
			flag_n <= i_res.y[DATA_W-1];
		end
	end

	// output port register
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			o_out_valid <= 1'b0;
			o_out_data <= '0;
		end
		else if (commit && i_res.kind == COMMIT_OUT)
		begin
			o_out_valid <= 1'b1;
			o_out_data <= i_res.y;
		end
		else if (i_out_ready)
			o_out_valid <= 1'b0;
	end

endmodule

//--- verification/pat_model.svh
data_t m_regs [8];
logic m_z;
logic m_n;
data_t exp_q [$]; // values the output port must deliver in order

task automatic reset_model;
	for (int i = 0; i < 8; i++)
		m_regs[i] = 8'h00;
	m_z = 1'b1; // z comes out of reset set
	m_n = 1'b0;
	exp_q.delete();
endtask

function automatic logic cond_met(cond_e c);
	case (c)
		COND_Z: return m_z;
		COND_NZ: return !m_z;
		COND_N: return m_n;
		default: return 1'b1;
	endcase
endfunction

// amt + 1 single-place steps
function automatic data_t shift_by(data_t v, logic [1:0] amt, logic left, logic fill);
	for (int k = 0; k <= int'(amt); k++)
		v = left ? {v[6:0], fill} : {fill, v[7:1]};
	return v;
endfunction

// runs one instruction in program order as the core accepts it
task automatic run_instr(instr_t ins, data_t p0, data_t p1, data_t p2);
	data_t a;
	data_t rb;
	data_t imm;
	logic [3:0] op3;
	logic [3:0] op0;
	logic [2:0] r3;
	a = m_regs[ins.rn];
	imm = ins.imm8;
	r3 = imm[2:0];
	rb = m_regs[r3]; // second register for the register forms
	op3 = imm[7:4];
	op0 = imm[3:0];
	if (!cond_met(ins.cond))
		return;
	if (ins.opcode_i8 != 4'hF)
	begin
		case (ins.opcode_i8)
			4'h0: m_regs[ins.rn] = a | imm;
			4'h1: m_regs[ins.rn] = a | rb;
			4'h2: m_regs[ins.rn] = a & imm;
			4'h3: m_regs[ins.rn] = a & rb;
			4'h4: m_regs[ins.rn] = a + imm;
			4'h5: m_regs[ins.rn] = a + rb;
			4'h6: m_regs[ins.rn] = a - imm;
			4'h7: m_regs[ins.rn] = a - rb;
			4'h8: m_regs[ins.rn] = imm;
			default: ; // unused codes do nothing
		endcase
	end
	else if (op3 != 4'hF)
	begin
		// codes 0..7 are shifts
		// bit 2 selects right, bit 1 one fill, bit 0 a register amount
		if (op3 < 4'h8)
			m_regs[ins.rn] = shift_by(a, op3[0] ? rb[1:0] : imm[1:0], !op3[2], op3[1]);
		else if (op3 == 4'h8)
			m_regs[ins.rn] = (r3 == 3'b010) ? p1 : (r3 == 3'b100) ? p2 : p0;
		else if (op3 == 4'hB)
			exp_q.push_back(a);
	end
	else if (op0 == 4'h0)
		m_regs[ins.rn] = ~a;
	else if (op0 == 4'h2)
	begin
		m_z = (a == 8'h00);
		m_n = a[7];
	end
endtask

//--- verification/pat_tb.sv
`timescale 1ns/100ps

module pat_tb;
	import pat_pkg::*;

	localparam int N_INSTR = 400;
	localparam int CLK_NS = 8;
	localparam int SEED = 32'h74c1_b2df;

	logic clk;
	logic reset;
	logic i_instr_valid;
	instr_t i_instr;
	data_t i_in_data [N_IN_PORTS];
	logic i_out_ready;
	logic o_instr_ready;
	logic o_out_valid;
	data_t o_out_data;

	int n_offered, n_accepted, n_out;
	int data_errors, other_errors;
	int bp_left;
	logic bp_ready;
	logic offer_open; // instruction on the bus and not yet taken
	logic out_waiting;
	data_t held_data;
	int drain;

	`include "pat_model.svh"

	tb_clock #(.PERIOD_NS(CLK_NS)) u_clock (.o_clk(clk));

	pat_core u_pat_core (
		.clk(clk), .reset(reset),
		.i_instr_valid(i_instr_valid), .i_instr(i_instr), .i_in_data(i_in_data),
		.i_out_ready(i_out_ready), .o_instr_ready(o_instr_ready),
		.o_out_valid(o_out_valid), .o_out_data(o_out_data)
	);

	// ========================================
	// stimulus
	// ========================================
	function automatic instr_t gen_instr();
		logic [31:0] r;
		instr_t ins;
		int pick;
		r = $urandom;
		ins = r[22:0]; // reserved fields keep random bits
		pick = $urandom_range(99);
		if (pick < 30)
			ins.opcode_i8 = 4'($urandom_range(8));
		else if (pick < 33)
			ins.opcode_i8 = 4'($urandom_range(14, 9)); // dropped i8 codes
		else
		begin
			ins.opcode_i8 = 4'hF;
			if (pick < 50)
				ins.imm8[7:4] = 4'($urandom_range(7));
			else if (pick < 58)
			begin
				ins.imm8[7:4] = 4'h8;
				if ($urandom_range(3) != 0)
					ins.imm8[2:0] = 3'(1 << $urandom_range(2)); // one-hot port
			end
			else if (pick < 78)
				ins.imm8[7:4] = 4'hB;
			else if (pick < 81)
				ins.imm8[7:4] = 4'($urandom_range(14, 9));
			else
			begin
				ins.imm8[7:4] = 4'hF;
				if (pick < 88)
					ins.imm8[3:0] = 4'h0;
				else if (pick < 96)
					ins.imm8[3:0] = 4'h2;
				else
					ins.imm8[3:0] = 4'($urandom_range(15)); // nop and unknown i0
			end
		end
		ins.cond = ($urandom_range(1) == 0) ? COND_AL : cond_e'(2'($urandom_range(3)));
		return ins;
	endfunction

	task automatic drive_inputs;
		logic [31:0] r;
		instr_t next;
		if (bp_left == 0)
		begin
			bp_left = 1 + $urandom_range(6); // stretches of ready or stall
			bp_ready = ($urandom_range(2) != 0);
		end
		bp_left--;
		i_out_ready <= bp_ready;
		if (offer_open)
			return;
		if (n_offered < N_INSTR && $urandom_range(3) != 0)
		begin
			next = gen_instr();
			if (n_offered == 0)
			begin
				next.rn = 3'd0;
				next.cond = COND_Z;
				next.opcode_i8 = 4'hF;
				next.imm8 = 8'hB0; // out r0 under z before any test
			end
			i_instr <= next;
			i_instr_valid <= 1'b1;
			offer_open = 1'b1;
			n_offered++;
		end
		else
		begin
			i_instr_valid <= 1'b0;
			for (int p = 0; p < N_IN_PORTS; p++)
			begin
				r = $urandom;
				i_in_data[p] <= r[7:0]; // ports only move while nothing is offered
			end
		end
	endtask

	// ========================================
	// checking
	// ========================================
	task automatic take_output;
		data_t exp;
		if (exp_q.size() == 0)
		begin
			$display("unexpected output 0x%02h when none was due", o_out_data);
			other_errors++;
			return;
		end
		exp = exp_q.pop_front();
		if (o_out_data !== exp)
		begin
			$display("Fail o_out_data expected 0x%02h got 0x%02h", exp, o_out_data);
			data_errors++;
		end
		n_out++;
	endtask

	// values seen here are the ones from just before the edge
	task automatic check_edge;
		if (out_waiting)
		begin
			if (!o_out_valid)
			begin
				$display("output valid dropped before 0x%02h was taken", held_data);
				other_errors++;
			end
			else if (o_out_data !== held_data)
			begin
				$display("Fail o_out_data while stalled expected 0x%02h got 0x%02h",
					held_data, o_out_data);
				data_errors++;
			end
		end
		if (o_out_valid && i_out_ready)
			take_output();
		out_waiting = o_out_valid && !i_out_ready;
		held_data = o_out_data;
		if (i_instr_valid && o_instr_ready)
		begin
			run_instr(i_instr, i_in_data[0], i_in_data[1], i_in_data[2]);
			offer_open = 1'b0;
			n_accepted++;
		end
	endtask

	initial
	begin
		void'($urandom(SEED));
		reset_model();
		n_offered = 0;
		n_accepted = 0;
		n_out = 0;
		data_errors = 0;
		other_errors = 0;
		bp_left = 0;
		bp_ready = 1'b1;
		offer_open = 1'b0;
		out_waiting = 1'b0;
		held_data = 8'h00;
		reset <= 1'b1;
		i_instr_valid <= 1'b0;
		i_instr <= '0;
		i_out_ready <= 1'b1;
		for (int p = 0; p < N_IN_PORTS; p++)
			i_in_data[p] <= 8'h00;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		if (o_out_valid !== 1'b0)
		begin
			$display("Fail o_out_valid expected 0x0 got 0x%0h", o_out_valid);
			data_errors++;
		end
		if (o_instr_ready !== 1'b1)
		begin
			$display("Fail o_instr_ready expected 0x1 got 0x%0h", o_instr_ready);
			data_errors++;
		end
		while (n_accepted < N_INSTR)
		begin
			drive_inputs();
			@(posedge clk);
			check_edge();
		end
		// let the last results drain with the port always ready
		i_instr_valid <= 1'b0;
		drain = 0;
		while ((exp_q.size() != 0 || o_out_valid) && drain < 40)
		begin
			i_out_ready <= 1'b1;
			@(posedge clk);
			check_edge();
			drain++;
		end
		repeat (8)
		begin
			@(posedge clk);
			check_edge(); // anything still coming out is a duplicate
		end
		if (exp_q.size() != 0)
		begin
			$display("%0d expected outputs never appeared", exp_q.size());
			other_errors++;
		end
		$display("%0d outputs checked, %0d value errors, %0d other errors",
			n_out, data_errors, other_errors);
		if (data_errors == 0 && other_errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	// watchdog
	initial
	begin
		#(N_INSTR * 20 * CLK_NS);
		$display("timeout with %0d of %0d instructions accepted", n_accepted, N_INSTR);
		$display("%0d outputs checked, %0d value errors, %0d other errors",
			n_out, data_errors, other_errors);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- verification/tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
	parameter int PERIOD_NS = 8
) (
	output logic o_clk
);

	initial
	begin
		o_clk = 1'b0;
		forever #(PERIOD_NS / 2) o_clk = ~o_clk; // first rising edge at half a period
	end

endmodule
